/* rtl/upsp_pkg.sv */
// ==========================================================================
// Shared types of the 2x up-sampler: pixel and stream beat, register words,
// register map, flag position and the FSM state encodings
// ==========================================================================
package upsp_pkg;

	// One pixel word, source and destination alike
	typedef logic [31:0] pixel_t;

	// AXI-Stream beat, data plus last
	typedef struct packed {
		pixel_t data;
		logic   last;
	} axis_beat_t;

	typedef logic [1:0]  reg_addr_t;
	typedef logic [31:0] reg_data_t;

	// Register map
	localparam reg_addr_t REG_UPSTR  = 2'd0;
	localparam reg_addr_t REG_UPENDR = 2'd1;

	// Start and end flags use the same bit of their register
	localparam int FLAG_BIT = 0;

	// Control register file states
	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_BUSY,
		CTRL_DONE
	} ctrl_state_t;

	// Up-sampler states
	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_FETCH,
		CORE_EMIT,
		CORE_NEXT
	} core_state_t;

endpackage

/* rtl/stream_in.sv */
// ==========================================================================
// AXI-Stream slave with a small pixel FIFO serving core read requests
// ==========================================================================
`timescale 1ns/100ps

module stream_in #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 s_valid,
	output logic                 s_ready,
	input  upsp_pkg::axis_beat_t s_beat,
	input  logic                 pix_rd,
	output logic                 pix_rvalid,
	output upsp_pkg::pixel_t     pix_rdata
);
	import upsp_pkg::*;

	localparam int PW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	pixel_t        fifo_mem [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          pending;
	logic          req;
	logic          push;
	logic          pop;

	assign s_ready = (count != CW'(FIFO_DEPTH));
	assign push    = s_valid && s_ready;
	// A new strobe or one still waiting for data
	assign req     = pix_rd || pending;
	assign pop     = req && (count != '0);

	// Only the pixel is kept, last is not needed downstream
	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= s_beat.data;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			pix_rdata <= fifo_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			pending    <= 1'b0;
			pix_rvalid <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CW'(push) - CW'(pop);
			// Request parks here while the FIFO is empty
			pending    <= req && !pop;
			pix_rvalid <= pop;
		end
	end

	// A beat offered to a full FIFO is held until it is taken
	a_hold_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		s_valid && !s_ready |=> s_valid && $stable(s_beat));

	// Core waits for rvalid before the next strobe
	a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
		pending |-> !pix_rd);

endmodule

/* rtl/upsp_core.sv */
// ==========================================================================
// Nearest-neighbour 2x up-sampler, fetches a source row and writes every
// pixel twice across and the whole row twice down
// ==========================================================================
`timescale 1ns/100ps

module upsp_core #(
	parameter int SRC_W = 4,
	parameter int SRC_H = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             frame_go,
	output logic             pix_rd,
	input  logic             pix_rvalid,
	input  upsp_pkg::pixel_t pix_rdata,
	output logic             wrt,
	input  logic             wready,
	output upsp_pkg::pixel_t wdata
);
	import upsp_pkg::*;

	localparam int DST_W = 2 * SRC_W;
	// SRC_W is a power of two so the counter splits cleanly into fields
	localparam int XW    = $clog2(SRC_W);
	localparam int DW    = $clog2(2 * DST_W);
	localparam int RW    = (SRC_H > 1) ? $clog2(SRC_H) : 1;

	core_state_t   state;
	pixel_t        row_buf [SRC_W];
	logic [XW-1:0] fetch_cnt;
	logic          rd_busy;
	logic [DW-1:0] dst_cnt;
	logic [XW-1:0] src_col;
	logic [RW-1:0] row_cnt;
	logic          wr_fire;

	assign pix_rd  = (state == CORE_FETCH) && !rd_busy;
	assign wrt     = (state == CORE_EMIT);
	assign wr_fire = wrt && wready;

	// dst_cnt is {row copy, source column, pixel copy}
	assign src_col = dst_cnt[XW:1];
	assign wdata   = row_buf[src_col];

	// Row store
	always_ff @(posedge clk) begin
		if (pix_rvalid && (state == CORE_FETCH)) begin
			row_buf[fetch_cnt] <= pix_rdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= CORE_IDLE;
			fetch_cnt <= '0;
			rd_busy   <= 1'b0;
			dst_cnt   <= '0;
			row_cnt   <= '0;
		end else begin
			case (state)
				CORE_IDLE: begin
					if (frame_go) begin
						state     <= CORE_FETCH;
						fetch_cnt <= '0;
						rd_busy   <= 1'b0;
						row_cnt   <= '0;
					end
				end
				CORE_FETCH: begin
					if (pix_rd) begin
						rd_busy <= 1'b1;
					end
					if (pix_rvalid) begin
						rd_busy   <= 1'b0;
						fetch_cnt <= fetch_cnt + 1'b1;
						if (fetch_cnt == XW'(SRC_W - 1)) begin
							state   <= CORE_EMIT;
							dst_cnt <= '0;
						end
					end
				end
				CORE_EMIT: begin
					// Stalls here while both output banks are full
					if (wr_fire) begin
						dst_cnt <= dst_cnt + 1'b1;
						if (dst_cnt == DW'(2 * DST_W - 1)) begin
							state <= CORE_NEXT;
						end
					end
				end
				CORE_NEXT: begin
					fetch_cnt <= '0;
					if (row_cnt == RW'(SRC_H - 1)) begin
						state <= CORE_IDLE;
					end else begin
						row_cnt <= row_cnt + 1'b1;
						state   <= CORE_FETCH;
					end
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// Read data only comes back for a strobe still outstanding
	a_rvalid_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		pix_rvalid |-> (state == CORE_FETCH) && rd_busy);

	// Controller only starts a frame once the previous one has drained
	a_go_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		frame_go |-> (state == CORE_IDLE));

endmodule

/* rtl/out_pingpong.sv */
// ==========================================================================
// Output side, two ping-pong banks of two destination rows each and an
// AXI-Stream master that flags the last beat of the frame
// ==========================================================================
`timescale 1ns/100ps

module out_pingpong #(
	parameter int SRC_W = 4,
	parameter int SRC_H = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 wrt,
	output logic                 wready,
	input  upsp_pkg::pixel_t     wdata,
	output logic                 m_valid,
	input  logic                 m_ready,
	output upsp_pkg::axis_beat_t m_beat,
	output logic                 frame_done
);
	import upsp_pkg::*;

	// Two destination rows per bank
	localparam int BANK_WORDS = 4 * SRC_W;
	localparam int BW         = $clog2(BANK_WORDS);
	localparam int PW         = (SRC_H > 1) ? $clog2(SRC_H) : 1;

	pixel_t        bank_mem [2][BANK_WORDS];
	logic [1:0]    full;
	logic          wr_sel;
	logic [BW-1:0] wr_cnt;
	logic          rd_sel;
	logic [BW-1:0] rd_cnt;
	logic [PW-1:0] pair_cnt;
	logic          m_end;
	logic          wr_fire;
	logic          wr_bank_end;
	logic          rd_bank_end;
	logic          fire;
	logic          load;

	assign wready      = !(&full);
	assign wr_fire     = wrt && wready;
	assign wr_bank_end = (wr_cnt == BW'(BANK_WORDS - 1));
	assign rd_bank_end = (rd_cnt == BW'(BANK_WORDS - 1));
	assign fire        = m_valid && m_ready;

	// Next word is fetched when the output register is free or emptying.
	// rd_sel flips as a bank's final word is loaded, so the bank still in
	// flight is always the other one.
	assign load = full[rd_sel] && (!m_valid || fire);

	assign frame_done = fire && m_beat.last;

	// Bank storage and output beat
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bank_mem[wr_sel][wr_cnt] <= wdata;
		end
		if (load) begin
			m_beat.data <= bank_mem[rd_sel][rd_cnt];
			m_beat.last <= rd_bank_end && (pair_cnt == PW'(SRC_H - 1));
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full     <= 2'b00;
			wr_sel   <= 1'b0;
			wr_cnt   <= '0;
			rd_sel   <= 1'b0;
			rd_cnt   <= '0;
			pair_cnt <= '0;
			m_end    <= 1'b0;
			m_valid  <= 1'b0;
		end else begin
			// Write side
			if (wr_fire) begin
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_bank_end) begin
					full[wr_sel] <= 1'b1;
					wr_sel       <= !wr_sel;
					wr_cnt       <= '0;
				end
			end

			// Release a bank after its final beat has gone out
			if (fire && m_end) begin
				full[!rd_sel] <= 1'b0;
			end

			// Read side
			if (load) begin
				m_valid <= 1'b1;
				m_end   <= rd_bank_end;
				rd_cnt  <= rd_cnt + 1'b1;
				if (rd_bank_end) begin
					rd_cnt <= '0;
					rd_sel <= !rd_sel;
					if (pair_cnt == PW'(SRC_H - 1)) begin
						pair_cnt <= '0;
					end else begin
						pair_cnt <= pair_cnt + 1'b1;
					end
				end
			end else if (fire) begin
				m_valid <= 1'b0;
			end
		end
	end

	// Beat held steady under back-pressure
	a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

/* rtl/upsp_ctrl.sv */
// ==========================================================================
// Control register file with the start and end flags, frame start pulse
// and end-of-frame write-back
// ==========================================================================
`timescale 1ns/100ps

module upsp_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                reg_wr,
	input  upsp_pkg::reg_addr_t reg_addr,
	input  upsp_pkg::reg_data_t reg_wdata,
	output logic                upstr,
	output logic                upendr,
	output logic                frame_go,
	input  logic                frame_done
);
	import upsp_pkg::*;

	ctrl_state_t state;
	logic        start_wr;
	logic        end_wr;

	assign start_wr = reg_wr && (reg_addr == REG_UPSTR);
	assign end_wr   = reg_wr && (reg_addr == REG_UPENDR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= CTRL_IDLE;
			upstr    <= 1'b0;
			upendr   <= 1'b0;
			frame_go <= 1'b0;
		end else begin
			frame_go <= 1'b0;
			case (state)
				CTRL_IDLE: begin
					// Start only with a clear end flag
					if (start_wr && reg_wdata[FLAG_BIT] && !upendr) begin
						upstr    <= 1'b1;
						frame_go <= 1'b1;
						state    <= CTRL_BUSY;
					end else if (end_wr) begin
						upendr <= reg_wdata[FLAG_BIT];
					end
				end
				CTRL_BUSY: begin
					// Host writes have no effect mid-frame
					if (frame_done) begin
						upstr  <= 1'b0;
						upendr <= 1'b1;
						state  <= CTRL_DONE;
					end
				end
				CTRL_DONE: begin
					if (end_wr && !reg_wdata[FLAG_BIT]) begin
						upendr <= 1'b0;
						state  <= CTRL_IDLE;
					end
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	// Output side only finishes a frame that was started
	a_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> (state == CTRL_BUSY));

endmodule

/* rtl/upsp_top.sv */
// ==========================================================================
// Up-sampler top level: stream input, core, ping-pong output and control
// ==========================================================================
`timescale 1ns/100ps

module upsp_top #(
	parameter int SRC_W      = 4,
	parameter int SRC_H      = 2,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 reg_wr,
	input  upsp_pkg::reg_addr_t  reg_addr,
	input  upsp_pkg::reg_data_t  reg_wdata,
	output logic                 upstr,
	output logic                 upendr,
	input  logic                 s_valid,
	output logic                 s_ready,
	input  upsp_pkg::axis_beat_t s_beat,
	output logic                 m_valid,
	input  logic                 m_ready,
	output upsp_pkg::axis_beat_t m_beat
);
	import upsp_pkg::*;

	// Read request path
	logic   pix_rd;
	logic   pix_rvalid;
	pixel_t pix_rdata;

	// Write path into the banks
	logic   wrt;
	logic   wready;
	pixel_t wdata;

	logic   frame_go;
	logic   frame_done;

	stream_in #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_stream_in (
		.clk        (clk),
		.rst_n      (rst_n),
		.s_valid    (s_valid),
		.s_ready    (s_ready),
		.s_beat     (s_beat),
		.pix_rd     (pix_rd),
		.pix_rvalid (pix_rvalid),
		.pix_rdata  (pix_rdata)
	);

	upsp_core #(
		.SRC_W (SRC_W),
		.SRC_H (SRC_H)
	) u_upsp_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.frame_go   (frame_go),
		.pix_rd     (pix_rd),
		.pix_rvalid (pix_rvalid),
		.pix_rdata  (pix_rdata),
		.wrt        (wrt),
		.wready     (wready),
		.wdata      (wdata)
	);

	out_pingpong #(
		.SRC_W (SRC_W),
		.SRC_H (SRC_H)
	) u_out_pingpong (
		.clk        (clk),
		.rst_n      (rst_n),
		.wrt        (wrt),
		.wready     (wready),
		.wdata      (wdata),
		.m_valid    (m_valid),
		.m_ready    (m_ready),
		.m_beat     (m_beat),
		.frame_done (frame_done)
	);

	upsp_ctrl u_upsp_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.reg_wr     (reg_wr),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.upstr      (upstr),
		.upendr     (upendr),
		.frame_go   (frame_go),
		.frame_done (frame_done)
	);

endmodule

/* tb/tb_clkgen.sv */
// ==========================================================================
// Testbench clock and reset generator, 8 ns clock, reset held 5 cycles
// ==========================================================================
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Release just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

/* tb/tb_upsp.sv */
// ==========================================================================
// Up-sampler testbench: frame table, LFSR back-pressure and stream gaps,
// beat and flag compare tasks, cycle timeout
// ==========================================================================
`timescale 1ns/100ps

module tb_upsp;
	import upsp_pkg::*;

	localparam int SRC_W          = 4;
	localparam int SRC_H          = 2;
	localparam int NPIX           = SRC_W * SRC_H;
	localparam int DST_W          = 2 * SRC_W;
	localparam int NDST           = 4 * NPIX;
	localparam int N_TESTS        = 4;
	localparam int TIMEOUT_CYCLES = 400 * N_TESTS;

	logic       clk;
	logic       rst_n;
	logic       reg_wr;
	reg_addr_t  reg_addr;
	reg_data_t  reg_wdata;
	logic       upstr;
	logic       upendr;
	logic       s_valid;
	logic       s_ready;
	axis_beat_t s_beat;
	logic       m_valid;
	logic       m_ready;
	axis_beat_t m_beat;

	// Frame table
	string  test_name [N_TESTS];
	pixel_t src_pix [N_TESTS][NPIX];
	logic   use_gaps [N_TESTS];
	logic   poke_start [N_TESTS];

	logic [7:0] lfsr_state = 8'd83;
	int         cycle_cnt  = 0;

	tb_clkgen clkgen0 (
		.clk   (clk),
		.rst_n (rst_n)
	);

	upsp_top #(
		.SRC_W      (SRC_W),
		.SRC_H      (SRC_H),
		.FIFO_DEPTH (8)
	) dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.upstr     (upstr),
		.upendr    (upendr),
		.s_valid   (s_valid),
		.s_ready   (s_ready),
		.s_beat    (s_beat),
		.m_valid   (m_valid),
		.m_ready   (m_ready),
		.m_beat    (m_beat)
	);

	task automatic load_table();
		test_name[0]  = "ready_high_ramp";
		use_gaps[0]   = 1'b0;
		poke_start[0] = 1'b0;
		src_pix[0]    = '{32'h10000001, 32'h10000002, 32'h10000003, 32'h10000004,
			32'h20000001, 32'h20000002, 32'h20000003, 32'h20000004};
		test_name[1]  = "lfsr_backpressure";
		use_gaps[1]   = 1'b1;
		poke_start[1] = 1'b0;
		src_pix[1]    = '{32'hdeadbeef, 32'h01234567, 32'h89abcdef, 32'hfedcba98,
			32'h76543210, 32'h0f0f0f0f, 32'hf0f0f0f0, 32'h5a5aa5a5};
		test_name[2]  = "start_write_mid_frame";
		use_gaps[2]   = 1'b1;
		poke_start[2] = 1'b1;
		src_pix[2]    = '{32'h00000000, 32'hffffffff, 32'h80000000, 32'h00000001,
			32'h13579bdf, 32'h2468ace0, 32'hcafef00d, 32'h0badf00d};
		test_name[3]  = "frame_after_ignored_start";
		use_gaps[3]   = 1'b0;
		poke_start[3] = 1'b0;
		src_pix[3]    = '{32'h11111111, 32'h22222222, 32'h33333333, 32'h44444444,
			32'h55555555, 32'h66666666, 32'h77777777, 32'h88888888};
	endtask

	// Taps 8,6,5,4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		logic fb;
		fb = s[7] ^ s[5] ^ s[4] ^ s[3];
		return {s[6:0], fb};
	endfunction

	function logic take_lfsr_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// Destination pixel (x, y) comes from source pixel (x/2, y/2)
	function automatic axis_beat_t expected_beat(input int t, input int k);
		axis_beat_t b;
		int         x;
		int         y;
		y      = k / DST_W;
		x      = k % DST_W;
		b.data = src_pix[t][(y / 2) * SRC_W + x / 2];
		b.last = (k == NDST - 1);
		return b;
	endfunction

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_beat(input string what, input axis_beat_t exp, input axis_beat_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected data %h last %b, actual data %h last %b",
				what, exp.data, exp.last, act.data, act.last);
			abort_run();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s: expected %b, actual %b", what, exp, act);
			abort_run();
		end
	endtask

	// One-cycle register write, called just after an edge
	task automatic write_reg(input reg_addr_t a, input reg_data_t d);
		reg_wr    = 1'b1;
		reg_addr  = a;
		reg_wdata = d;
		@(posedge clk);
		#1;
		reg_wr = 1'b0;
	endtask

	task automatic run_frame(input int t);
		int    in_idx;
		int    out_idx;
		logic  gap;
		logic  s_took;
		logic  poked;
		string nm;
		in_idx  = 0;
		out_idx = 0;
		poked   = 1'b0;
		nm      = test_name[t];
		write_reg(REG_UPSTR, 32'd1);
		check_flag($sformatf("%s upstr after start", nm), 1'b1, upstr);
		while (out_idx < NDST) begin
			if (!s_valid && in_idx < NPIX) begin
				gap = 1'b0;
				if (use_gaps[t]) begin
					gap = take_lfsr_bit();
				end
				if (!gap) begin
					s_beat.data = src_pix[t][in_idx];
					s_beat.last = (in_idx == NPIX - 1);
					s_valid     = 1'b1;
				end
			end
			if (use_gaps[t]) begin
				m_ready = take_lfsr_bit();
			end else begin
				m_ready = 1'b1;
			end
			reg_wr = 1'b0;
			// Second start while busy, must be ignored
			if (poke_start[t] && !poked && out_idx == 4) begin
				reg_wr    = 1'b1;
				reg_addr  = REG_UPSTR;
				reg_wdata = 32'd1;
				poked     = 1'b1;
			end
			// Beats that transfer on the coming edge
			if (m_valid && m_ready) begin
				check_beat($sformatf("%s beat %0d", nm, out_idx),
					expected_beat(t, out_idx), m_beat);
				out_idx++;
			end
			s_took = s_valid && s_ready;
			@(posedge clk);
			#1;
			if (s_took) begin
				s_valid = 1'b0;
				in_idx++;
			end
		end
		reg_wr = 1'b0;
		check_flag($sformatf("%s upstr at end", nm), 1'b0, upstr);
		check_flag($sformatf("%s upendr at end", nm), 1'b1, upendr);
		// No extra beats after the frame
		repeat (8) begin
			check_flag($sformatf("%s m_valid after end", nm), 1'b0, m_valid);
			@(posedge clk);
			#1;
		end
		write_reg(REG_UPENDR, 32'd0);
		check_flag($sformatf("%s upendr cleared", nm), 1'b0, upendr);
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("timeout: the frames did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	initial begin
		reg_wr    = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;
		s_valid   = 1'b0;
		s_beat    = '0;
		m_ready   = 1'b0;
		load_table();
		wait (rst_n === 1'b1);
		check_flag("reset upstr", 1'b0, upstr);
		check_flag("reset upendr", 1'b0, upendr);
		check_flag("reset m_valid", 1'b0, m_valid);
		check_flag("reset s_ready", 1'b1, s_ready);
		for (int t = 0; t < N_TESTS; t++) begin
			run_frame(t);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* compile.f */
rtl/upsp_pkg.sv
rtl/stream_in.sv
rtl/upsp_core.sv
rtl/out_pingpong.sv
rtl/upsp_ctrl.sv
rtl/upsp_top.sv
tb/tb_clkgen.sv
tb/tb_upsp.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_upsp -f compile.f -o sim_upsp \
	&& ./obj_dir/sim_upsp > sim.log 2>&1

grep -q "Result: PASSED" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
